// ==== hw/branch_unit_config.svh ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths for the branch resolution unit
// BU_XLEN may be 32 or 64; PC step assumes no compressed instructions
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef BRANCH_UNIT_CONFIG_SVH
`define BRANCH_UNIT_CONFIG_SVH

// Operand, PC and target width
`define BU_XLEN 32

// Fall-through PC increment
`define BU_PC_STEP 4

`endif

// ==== hw/branch_unit_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types of the branch resolution unit
// Users refer to items with scoped names; nothing here is imported
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "branch_unit_config.svh"

package branch_unit_pkg;

  // Operands, PCs, immediates and targets
  typedef logic [`BU_XLEN-1:0] xlen_t;

  // funct3 encodings of the B-type branches
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // Comparison chosen by decode, consumed by execute
  typedef enum logic [2:0] {
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE,
    BR_LTU,
    BR_GEU
  } branch_op_t;

  // Result controller states
  // Good or bad tells whether the prediction matched,
  // T or NT is the resolved direction
  typedef enum logic [2:0] {
    CU_RESET,
    CU_WAIT_OPS,
    CU_GOOD_T,
    CU_GOOD_NT,
    CU_BAD_T,
    CU_BAD_NT
  } cu_state_t;

endpackage

// ==== hw/branch_decode.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One-entry decode stage; inputs must hold while op_valid_i waits
// funct3 010 and 011 are flagged illegal and decode as BR_EQ
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module branch_decode (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  // Branch from the front end
  input  logic                       op_valid_i,
  output logic                       op_ready_o,
  input  logic [2:0]                 funct3_i,
  input  branch_unit_pkg::xlen_t     rs1_i,
  input  branch_unit_pkg::xlen_t     rs2_i,
  input  branch_unit_pkg::xlen_t     pc_i,
  input  branch_unit_pkg::xlen_t     imm_i,
  input  logic                       pred_taken_i,
  input  branch_unit_pkg::xlen_t     pred_target_i,
  // Decoded branch towards execute
  output logic                       dec_valid_o,
  input  logic                       dec_ready_i,
  output branch_unit_pkg::branch_op_t dec_op_o,
  output logic                       dec_illegal_o,
  output branch_unit_pkg::xlen_t     dec_rs1_o,
  output branch_unit_pkg::xlen_t     dec_rs2_o,
  output branch_unit_pkg::xlen_t     dec_pc_o,
  output branch_unit_pkg::xlen_t     dec_imm_o,
  output branch_unit_pkg::xlen_t     dec_pred_target_o,
  output logic                       dec_pred_taken_o
);

  logic                        live_q;
  logic                        valid_q;
  logic                        load;
  branch_unit_pkg::branch_op_t op_d;
  logic                        illegal_d;

  // Ready once out of reset, when empty or when draining this edge
  assign op_ready_o  = live_q & (~valid_q | dec_ready_i);
  assign load        = op_valid_i & op_ready_o;
  assign dec_valid_o = valid_q;

  // funct3 to comparison
  always_comb begin
    op_d      = branch_unit_pkg::BR_EQ;
    illegal_d = 1'b0;
    case (funct3_i)
      branch_unit_pkg::F3_BEQ:  op_d = branch_unit_pkg::BR_EQ;
      branch_unit_pkg::F3_BNE:  op_d = branch_unit_pkg::BR_NE;
      branch_unit_pkg::F3_BLT:  op_d = branch_unit_pkg::BR_LT;
      branch_unit_pkg::F3_BGE:  op_d = branch_unit_pkg::BR_GE;
      branch_unit_pkg::F3_BLTU: op_d = branch_unit_pkg::BR_LTU;
      branch_unit_pkg::F3_BGEU: op_d = branch_unit_pkg::BR_GEU;
      default:                  illegal_d = 1'b1;
    endcase
  end

  // Occupancy
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      live_q  <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      live_q <= 1'b1;
      if (load) begin
        valid_q <= 1'b1;
      end else if (dec_ready_i) begin
        valid_q <= 1'b0;
      end
    end
  end

  // Payload, written only on an accepted branch
  always_ff @(posedge clk_i) begin
    if (load) begin
      dec_op_o          <= op_d;
      dec_illegal_o     <= illegal_d;
      dec_rs1_o         <= rs1_i;
      dec_rs2_o         <= rs2_i;
      dec_pc_o          <= pc_i;
      dec_imm_o         <= imm_i;
      dec_pred_target_o <= pred_target_i;
      dec_pred_taken_o  <= pred_taken_i;
    end
  end

  // A stalled entry keeps its valid and its contents
  a_dec_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dec_valid_o && !dec_ready_i |=>
      dec_valid_o && $stable(dec_op_o) && $stable(dec_pc_o) && $stable(dec_illegal_o));

endmodule

// ==== hw/branch_execute.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One-entry execute stage resolving direction, next PC and prediction
// wrong_target is raw; the result FSM applies it only to taken branches
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "branch_unit_config.svh"

module branch_execute (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  // Decoded branch
  input  logic                        dec_valid_i,
  output logic                        dec_ready_o,
  input  branch_unit_pkg::branch_op_t dec_op_i,
  input  logic                        dec_illegal_i,
  input  branch_unit_pkg::xlen_t      dec_rs1_i,
  input  branch_unit_pkg::xlen_t      dec_rs2_i,
  input  branch_unit_pkg::xlen_t      dec_pc_i,
  input  branch_unit_pkg::xlen_t      dec_imm_i,
  input  branch_unit_pkg::xlen_t      dec_pred_target_i,
  input  logic                        dec_pred_taken_i,
  // Resolved outcome towards the result FSM
  output logic                        exe_valid_o,
  input  logic                        exe_ready_i,
  output logic                        exe_taken_o,
  output logic                        exe_wrong_taken_o,
  output logic                        exe_wrong_target_o,
  output logic                        exe_illegal_o,
  output branch_unit_pkg::xlen_t      exe_next_pc_o
);

  logic                   live_q;
  logic                   valid_q;
  logic                   load;
  logic                   cmp;
  logic                   taken;
  branch_unit_pkg::xlen_t target;
  branch_unit_pkg::xlen_t seq_pc;

  assign dec_ready_o = live_q & (~valid_q | exe_ready_i);
  assign load        = dec_valid_i & dec_ready_o;
  assign exe_valid_o = valid_q;

  // Selected comparison
  always_comb begin
    cmp = 1'b0;
    case (dec_op_i)
      branch_unit_pkg::BR_EQ:  cmp = (dec_rs1_i == dec_rs2_i);
      branch_unit_pkg::BR_NE:  cmp = (dec_rs1_i != dec_rs2_i);
      branch_unit_pkg::BR_LT:  cmp = ($signed(dec_rs1_i) < $signed(dec_rs2_i));
      branch_unit_pkg::BR_GE:  cmp = ($signed(dec_rs1_i) >= $signed(dec_rs2_i));
      branch_unit_pkg::BR_LTU: cmp = (dec_rs1_i < dec_rs2_i);
      branch_unit_pkg::BR_GEU: cmp = (dec_rs1_i >= dec_rs2_i);
      default:                 cmp = 1'b0;
    endcase
  end

  // Illegal funct3 never takes
  assign taken = cmp & ~dec_illegal_i;

  // Both candidate PCs
  assign target = dec_pc_i + dec_imm_i;
  assign seq_pc = dec_pc_i + branch_unit_pkg::xlen_t'(`BU_PC_STEP);

  // Occupancy
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      live_q  <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      live_q <= 1'b1;
      if (load) begin
        valid_q <= 1'b1;
      end else if (exe_ready_i) begin
        valid_q <= 1'b0;
      end
    end
  end

  // Outcome registers
  always_ff @(posedge clk_i) begin
    if (load) begin
      exe_taken_o        <= taken;
      exe_wrong_taken_o  <= taken ^ dec_pred_taken_i;
      // Compared against the taken target even when falling through
      exe_wrong_target_o <= (dec_pred_target_i != target);
      exe_illegal_o      <= dec_illegal_i;
      exe_next_pc_o      <= taken ? target : seq_pc;
    end
  end

  // An illegal branch loaded here must come out not taken
  a_illegal_not_taken: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    load && dec_illegal_i |=> exe_valid_o && !exe_taken_o && exe_illegal_o);

endmodule

// ==== hw/branch_unit_cu.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Result controller; Moore FSM holding one result until res_ready_i
// Takes at most one branch every two cycles
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module branch_unit_cu (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // Outcome from execute
  input  logic                   exe_valid_i,
  output logic                   exe_ready_o,
  input  logic                   exe_taken_i,
  input  logic                   exe_wrong_taken_i,
  input  logic                   exe_wrong_target_i,
  input  logic                   exe_illegal_i,
  input  branch_unit_pkg::xlen_t exe_next_pc_i,
  // Result port
  output logic                   res_valid_o,
  input  logic                   res_ready_i,
  output logic                   res_taken_o,
  output logic                   res_mispredict_o,
  output logic                   res_illegal_o,
  output branch_unit_pkg::xlen_t res_next_pc_o
);

  branch_unit_pkg::cu_state_t state_q;
  branch_unit_pkg::cu_state_t state_d;
  logic                       exe_fire;
  logic                       illegal_q;
  branch_unit_pkg::xlen_t     next_pc_q;

  assign exe_fire = exe_valid_i & exe_ready_o;

  // State register
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= branch_unit_pkg::CU_RESET;
    end else begin
      state_q <= state_d;
    end
  end

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      branch_unit_pkg::CU_RESET: begin
        state_d = branch_unit_pkg::CU_WAIT_OPS;
      end
      branch_unit_pkg::CU_WAIT_OPS: begin
        if (exe_fire) begin
          // Target only matters when the branch is taken
          if (exe_taken_i) begin
            state_d = (exe_wrong_taken_i || exe_wrong_target_i) ?
                      branch_unit_pkg::CU_BAD_T : branch_unit_pkg::CU_GOOD_T;
          end else begin
            state_d = exe_wrong_taken_i ?
                      branch_unit_pkg::CU_BAD_NT : branch_unit_pkg::CU_GOOD_NT;
          end
        end
      end
      branch_unit_pkg::CU_GOOD_T,
      branch_unit_pkg::CU_GOOD_NT,
      branch_unit_pkg::CU_BAD_T,
      branch_unit_pkg::CU_BAD_NT: begin
        // Hold until the consumer takes it
        if (res_ready_i) begin
          state_d = branch_unit_pkg::CU_WAIT_OPS;
        end
      end
      default: begin
        state_d = branch_unit_pkg::CU_RESET;
      end
    endcase
  end

  // Payload not encoded in the state
  always_ff @(posedge clk_i) begin
    if (exe_fire) begin
      next_pc_q <= exe_next_pc_i;
      illegal_q <= exe_illegal_i;
    end
  end

  assign res_next_pc_o = next_pc_q;
  assign res_illegal_o = illegal_q;

  // Moore outputs
  always_comb begin
    exe_ready_o      = 1'b0;
    res_valid_o      = 1'b0;
    res_taken_o      = 1'b0;
    res_mispredict_o = 1'b0;
    case (state_q)
      branch_unit_pkg::CU_WAIT_OPS: exe_ready_o = 1'b1;
      branch_unit_pkg::CU_GOOD_T: begin
        res_valid_o = 1'b1;
        res_taken_o = 1'b1;
      end
      branch_unit_pkg::CU_GOOD_NT: res_valid_o = 1'b1;
      branch_unit_pkg::CU_BAD_T: begin
        res_valid_o      = 1'b1;
        res_taken_o      = 1'b1;
        res_mispredict_o = 1'b1;
      end
      branch_unit_pkg::CU_BAD_NT: begin
        res_valid_o      = 1'b1;
        res_mispredict_o = 1'b1;
      end
      default: ;
    endcase
  end

  // Result held steady under back-pressure
  a_res_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    res_valid_o && !res_ready_i |=> res_valid_o && $stable(res_taken_o) &&
      $stable(res_mispredict_o) && $stable(res_next_pc_o) && $stable(res_illegal_o));

  // No new outcome accepted while a result is presented
  a_no_ready_in_result: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    state_q inside {branch_unit_pkg::CU_GOOD_T, branch_unit_pkg::CU_GOOD_NT,
                    branch_unit_pkg::CU_BAD_T, branch_unit_pkg::CU_BAD_NT}
      |-> !exe_ready_o);

endmodule

// ==== hw/branch_unit.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Branch resolution unit top; decode, execute and result in a chain
// No flush; results come out in input order
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module branch_unit (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // Branch in
  input  logic                   op_valid_i,
  output logic                   op_ready_o,
  input  logic [2:0]             funct3_i,
  input  branch_unit_pkg::xlen_t rs1_i,
  input  branch_unit_pkg::xlen_t rs2_i,
  input  branch_unit_pkg::xlen_t pc_i,
  input  branch_unit_pkg::xlen_t imm_i,
  input  logic                   pred_taken_i,
  input  branch_unit_pkg::xlen_t pred_target_i,
  // Result out
  output logic                   res_valid_o,
  input  logic                   res_ready_i,
  output logic                   res_taken_o,
  output logic                   res_mispredict_o,
  output branch_unit_pkg::xlen_t res_next_pc_o,
  output logic                   res_illegal_o
);

  // Decode to execute
  logic                        dec_valid;
  logic                        dec_ready;
  branch_unit_pkg::branch_op_t dec_op;
  logic                        dec_illegal;
  branch_unit_pkg::xlen_t      dec_rs1;
  branch_unit_pkg::xlen_t      dec_rs2;
  branch_unit_pkg::xlen_t      dec_pc;
  branch_unit_pkg::xlen_t      dec_imm;
  branch_unit_pkg::xlen_t      dec_pred_target;
  logic                        dec_pred_taken;

  // Execute to result
  logic                        exe_valid;
  logic                        exe_ready;
  logic                        exe_taken;
  logic                        exe_wrong_taken;
  logic                        exe_wrong_target;
  logic                        exe_illegal;
  branch_unit_pkg::xlen_t      exe_next_pc;

  branch_decode u_decode (
    .clk_i, .rst_n_i,
    .op_valid_i, .op_ready_o, .funct3_i, .rs1_i, .rs2_i, .pc_i, .imm_i,
    .pred_taken_i, .pred_target_i,
    .dec_valid_o (dec_valid), .dec_ready_i (dec_ready), .dec_op_o (dec_op),
    .dec_illegal_o (dec_illegal), .dec_rs1_o (dec_rs1), .dec_rs2_o (dec_rs2),
    .dec_pc_o (dec_pc), .dec_imm_o (dec_imm),
    .dec_pred_target_o (dec_pred_target), .dec_pred_taken_o (dec_pred_taken)
  );

  branch_execute u_execute (
    .clk_i, .rst_n_i,
    .dec_valid_i (dec_valid), .dec_ready_o (dec_ready), .dec_op_i (dec_op),
    .dec_illegal_i (dec_illegal), .dec_rs1_i (dec_rs1), .dec_rs2_i (dec_rs2),
    .dec_pc_i (dec_pc), .dec_imm_i (dec_imm),
    .dec_pred_target_i (dec_pred_target), .dec_pred_taken_i (dec_pred_taken),
    .exe_valid_o (exe_valid), .exe_ready_i (exe_ready), .exe_taken_o (exe_taken),
    .exe_wrong_taken_o (exe_wrong_taken), .exe_wrong_target_o (exe_wrong_target),
    .exe_illegal_o (exe_illegal), .exe_next_pc_o (exe_next_pc)
  );

  branch_unit_cu u_cu (
    .clk_i, .rst_n_i,
    .exe_valid_i (exe_valid), .exe_ready_o (exe_ready), .exe_taken_i (exe_taken),
    .exe_wrong_taken_i (exe_wrong_taken), .exe_wrong_target_i (exe_wrong_target),
    .exe_illegal_i (exe_illegal), .exe_next_pc_i (exe_next_pc),
    .res_valid_o, .res_ready_i, .res_taken_o, .res_mispredict_o,
    .res_illegal_o, .res_next_pc_o
  );

endmodule

// ==== verification/tb_branch_unit.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for branch_unit; run from the project root
// Stimulus and expected results come from branch_stimulus.txt
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_branch_unit;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int    CLK_HALF        = 4;
  localparam int    RESET_CYCLES    = 8;
  localparam int    POST_RESET_IDLE = 4;
  localparam int    DRAIN_CYCLES    = 10;
  localparam int    CYCLES_PER_LINE = 20;
  localparam int    MAX_LINES       = 64;
  localparam string STIM_FILE       = "verification/branch_stimulus.txt";

  logic                   clk = 1'b0;
  logic                   rst_n;
  logic                   op_valid;
  logic                   op_ready;
  logic [2:0]             funct3;
  branch_unit_pkg::xlen_t rs1;
  branch_unit_pkg::xlen_t rs2;
  branch_unit_pkg::xlen_t pc;
  branch_unit_pkg::xlen_t imm;
  logic                   pred_taken;
  branch_unit_pkg::xlen_t pred_target;
  logic                   res_valid;
  logic                   res_ready;
  logic                   res_taken;
  logic                   res_mispredict;
  branch_unit_pkg::xlen_t res_next_pc;
  logic                   res_illegal;

  // One entry per stimulus line
  logic [2:0]             f3_mem       [MAX_LINES];
  branch_unit_pkg::xlen_t rs1_mem      [MAX_LINES];
  branch_unit_pkg::xlen_t rs2_mem      [MAX_LINES];
  branch_unit_pkg::xlen_t pc_mem       [MAX_LINES];
  branch_unit_pkg::xlen_t imm_mem      [MAX_LINES];
  logic                   ptaken_mem   [MAX_LINES];
  branch_unit_pkg::xlen_t ptarget_mem  [MAX_LINES];
  logic                   exp_taken    [MAX_LINES];
  logic                   exp_mispred  [MAX_LINES];
  branch_unit_pkg::xlen_t exp_next_pc  [MAX_LINES];
  logic                   exp_illegal  [MAX_LINES];

  int   num_lines;
  int   received;
  bit   loaded;
  // Result seen under back-pressure on the previous edge
  bit                     holding;
  logic                   held_taken;
  logic                   held_mispred;
  logic                   held_illegal;
  branch_unit_pkg::xlen_t held_next_pc;

  branch_unit dut_i (
    .clk_i (clk), .rst_n_i (rst_n),
    .op_valid_i (op_valid), .op_ready_o (op_ready), .funct3_i (funct3),
    .rs1_i (rs1), .rs2_i (rs2), .pc_i (pc), .imm_i (imm),
    .pred_taken_i (pred_taken), .pred_target_i (pred_target),
    .res_valid_o (res_valid), .res_ready_i (res_ready), .res_taken_o (res_taken),
    .res_mispredict_o (res_mispredict), .res_next_pc_o (res_next_pc),
    .res_illegal_o (res_illegal)
  );

  always #CLK_HALF clk = ~clk;

  // Multiplier and increment of the classic 32-bit LCG
  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic stop_with_failure();
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("Error: time %0t, %s expected %b, actual %b", $time, name, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic check_next_pc(input string name, input branch_unit_pkg::xlen_t expected,
                               input branch_unit_pkg::xlen_t actual);
    if (actual !== expected) begin
      $display("Error: time %0t, %s expected %0h, actual %0h", $time, name, expected, actual);
      stop_with_failure();
    end
  endtask

  // Lines starting with # are comments
  task automatic load_stimulus();
    int                     fd;
    int                     n;
    string                  line;
    logic [2:0]             f3;
    branch_unit_pkg::xlen_t a, b, p, im, tgt, npc;
    logic                   ptk, et, em, ei;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file %s", STIM_FILE);
      stop_with_failure();
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.getc(0) != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h",
                      f3, a, b, p, im, ptk, tgt, et, em, npc, ei);
          if (n == 11 && num_lines < MAX_LINES) begin
            f3_mem[num_lines]      = f3;
            rs1_mem[num_lines]     = a;
            rs2_mem[num_lines]     = b;
            pc_mem[num_lines]      = p;
            imm_mem[num_lines]     = im;
            ptaken_mem[num_lines]  = ptk;
            ptarget_mem[num_lines] = tgt;
            exp_taken[num_lines]   = et;
            exp_mispred[num_lines] = em;
            exp_next_pc[num_lines] = npc;
            exp_illegal[num_lines] = ei;
            num_lines++;
          end else if (n > 0) begin
            $display("Stimulus line %0d is malformed or beyond the table size", num_lines);
            stop_with_failure();
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Present one line and wait for its transfer edge
  task automatic present_branch(input int idx);
    @(negedge clk);
    op_valid    = 1'b1;
    funct3      = f3_mem[idx];
    rs1         = rs1_mem[idx];
    rs2         = rs2_mem[idx];
    pc          = pc_mem[idx];
    imm         = imm_mem[idx];
    pred_taken  = ptaken_mem[idx];
    pred_target = ptarget_mem[idx];
    @(posedge clk);
    while (!op_ready) @(posedge clk);
  endtask

  initial begin : main_sequence
    logic [31:0] gap_state;
    int          idle;
    rst_n       = 1'b0;
    op_valid    = 1'b0;
    funct3      = 3'b000;
    rs1         = '0;
    rs2         = '0;
    pc          = '0;
    imm         = '0;
    pred_taken  = 1'b0;
    pred_target = '0;
    gap_state   = 32'd31116;
    load_stimulus();
    if (num_lines == 0) begin
      $display("The stimulus file holds no branch lines");
      stop_with_failure();
    end
    loaded = 1'b1;
    // Both handshakes stay quiet in reset
    repeat (RESET_CYCLES) begin
      @(posedge clk);
      check_flag("op_ready_o", 1'b0, op_ready);
      check_flag("res_valid_o", 1'b0, res_valid);
    end
    @(negedge clk);
    rst_n = 1'b1;
    repeat (POST_RESET_IDLE) begin
      @(posedge clk);
      check_flag("res_valid_o", 1'b0, res_valid);
    end
    check_flag("op_ready_o", 1'b1, op_ready);
    for (int i = 0; i < num_lines; i++) begin
      present_branch(i);
      // Most lines go back-to-back and the rest wait up to 3 cycles
      gap_state = lcg_step(gap_state);
      idle = gap_state[31] ? 0 : int'(gap_state[30:29]);
      if (idle != 0) begin
        @(negedge clk);
        op_valid = 1'b0;
        repeat (idle - 1) @(negedge clk);
      end
    end
    @(negedge clk);
    op_valid = 1'b0;
    wait (received == num_lines);
    // Window for a stray extra result
    repeat (DRAIN_CYCLES) @(posedge clk);
    if (!res_valid) begin
      $display("Done: no errors");
      $finish;
    end else begin
      $display("A result was still presented after all %0d branches completed", num_lines);
      stop_with_failure();
    end
  end

  // Random back-pressure with ready high about 3 cycles in 4
  initial begin : drive_res_ready
    logic [31:0] ready_state;
    ready_state = 32'd31116;
    res_ready   = 1'b0;
    @(posedge rst_n);
    forever begin
      @(negedge clk);
      ready_state = lcg_step(ready_state);
      res_ready   = (ready_state[31:30] != 2'b00);
    end
  end

  always @(posedge clk) begin : monitor
    if (rst_n) begin
      if (holding) begin
        check_flag("res_valid_o", 1'b1, res_valid);
        check_flag("res_taken_o", held_taken, res_taken);
        check_flag("res_mispredict_o", held_mispred, res_mispredict);
        check_flag("res_illegal_o", held_illegal, res_illegal);
        check_next_pc("res_next_pc_o", held_next_pc, res_next_pc);
      end
      if (res_valid && res_ready) begin
        if (received >= num_lines) begin
          $display("A result arrived after every branch was already matched");
          stop_with_failure();
        end else begin
          check_flag("res_taken_o", exp_taken[received], res_taken);
          check_flag("res_mispredict_o", exp_mispred[received], res_mispredict);
          check_flag("res_illegal_o", exp_illegal[received], res_illegal);
          check_next_pc("res_next_pc_o", exp_next_pc[received], res_next_pc);
          received++;
        end
      end
      holding      = res_valid && !res_ready;
      held_taken   = res_taken;
      held_mispred = res_mispredict;
      held_illegal = res_illegal;
      held_next_pc = res_next_pc;
    end
  end

  initial begin : watchdog
    int limit;
    wait (loaded);
    limit = num_lines * CYCLES_PER_LINE + RESET_CYCLES + POST_RESET_IDLE + DRAIN_CYCLES;
    repeat (limit) @(posedge clk);
    $display("Timeout: results stopped arriving after %0d of %0d branches",
             received, num_lines);
    stop_with_failure();
  end

endmodule

// ==== verification/branch_stimulus.txt ====
# funct3 rs1 rs2 pc imm pred_taken pred_target, then expected taken mispredict next_pc illegal
# All fields hex; one branch per line
0 00000005 00000005 00001000 00000010 1 00001010 1 0 00001010 0
0 00000005 00000006 00001004 00000020 0 00001024 0 0 00001008 0
1 00000001 00000002 00001100 fffffff0 0 000010f0 1 1 000010f0 0
1 abcd0000 abcd0000 00002000 00000100 1 00002100 0 1 00002004 0
4 ffffffff 00000001 00003000 00000040 1 00003040 1 0 00003040 0
4 00000001 ffffffff 00003004 00000040 0 00000000 0 0 00003008 0
4 80000000 80000000 00003008 0000000c 0 00003014 0 0 0000300c 0
4 80000000 7fffffff 0000300c 00000800 1 00003800 1 1 0000380c 0
5 00000000 ffffffff 00004000 ffffff00 1 00003f00 1 0 00003f00 0
5 ffffff00 00000010 00004004 00000010 1 00004014 0 1 00004008 0
5 12345678 12345678 00004008 00000004 0 0000400c 1 1 0000400c 0
6 00000001 ffffffff 00005000 00000100 1 00005100 1 0 00005100 0
6 ffffffff 00000001 00005004 00000100 0 00005104 0 0 00005008 0
6 00000007 00000007 00005008 00000200 1 00005208 0 1 0000500c 0
7 ffffffff 00000001 00006000 fffff000 1 00005000 1 0 00005000 0
7 00000001 80000000 00006004 00000080 0 00006084 0 0 00006008 0
7 80000000 80000000 00006008 00000008 1 00006014 1 1 00006010 0
2 00000001 00000001 00007000 00000040 0 00007040 0 0 00007004 1
2 00000003 00000004 00007004 00000040 1 00007044 0 1 00007008 1
3 ffffffff ffffffff 00007008 fffffffc 0 00000000 0 0 0000700c 1
3 00000000 00000000 0000700c 00000010 1 0000701c 0 1 00007010 1
0 00000000 00000000 fffffffc 00000008 1 00000004 1 0 00000004 0
1 00000009 00000009 fffffffc 00000010 0 0000000c 0 0 00000000 0
4 fffffff0 fffffff8 00008000 00000020 0 00008020 1 1 00008020 0
5 fffffff0 fffffff8 00008004 00000020 0 00008024 0 0 00008008 0
1 00000000 80000000 00009000 00000ffe 1 00009ffe 1 0 00009ffe 0
0 deadbeef deadbeef 0000a000 fffff800 1 0000a800 1 1 00009800 0
7 00000000 00000001 0000b000 00000100 1 00000000 0 1 0000b004 0

// ==== list.f ====
+incdir+hw
hw/branch_unit_pkg.sv
hw/branch_decode.sv
hw/branch_execute.sv
hw/branch_unit_cu.sv
hw/branch_unit.sv
verification/tb_branch_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the branch unit testbench with Verilator
# Pass or fail is read from sim.log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

# RTL files carry no timescale, so give them the testbench one
verilator --binary --assert --timescale 1ns/100ps \
  --top-module tb_branch_unit -f list.f -o tb_branch_unit

# Exit status of the pipe is tee's, the log decides
./obj_dir/tb_branch_unit | tee sim.log

if grep -q "^Done: no errors$" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
